//--- filelist.f
matrix_pkg.sv
matrix_index_counter.sv
matrix_add_fsm.sv
modular_add_sub.sv
matrix_modular_adder.sv
tb_matrix_modular_adder.sv

//--- matrix_add_fsm.sv
/* Matrix add job sequencer */

`timescale 1ns/1ps

module matrix_add_fsm (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  matrix_pkg::mat_cfg_t cfg_in,
  input  logic                 pair_ready,
  input  logic                 row_end,
  input  logic                 last,
  output matrix_pkg::mat_cfg_t cfg,
  output logic                 busy,
  output logic                 compute,
  output logic                 clear,
  output logic                 advance,
  output logic                 out_valid,
  output logic                 out_row_end,
  output logic                 out_last,
  output logic                 done
);

  // Job state
  typedef enum logic {
    st_idle,
    st_run
  } state_e;

  state_e state;

  //////////////////////////////////////////////////
  // Handshake decode
  //////////////////////////////////////////////////

  assign busy    = (state == st_run);

  // Fire one element as soon as both operands are held
  assign compute = busy && pair_ready;
  // Counter steps on the same edge as the datapath
  assign advance = compute;

  // Accepted start resets the position
  assign clear   = !busy && start;

  //////////////////////////////////////////////////
  // State register
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_run;
          end
        end
        st_run: begin
          // Final element fired
          if (compute && last) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Configuration held for the whole job
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      cfg <= '0;
    end else if (clear) begin
      cfg <= cfg_in;
    end
  end

  //////////////////////////////////////////////////
  // Output flags
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid   <= 1'b0;
      out_row_end <= 1'b0;
      out_last    <= 1'b0;
      done        <= 1'b0;
    end else begin
      out_valid <= compute;
      done      <= compute && last;
      // Markers travel with the registered result
      if (compute) begin
        out_row_end <= row_end;
        out_last    <= last;
      end
    end
  end

  // Job end comes with the final element of the last row
  a_done_with_last : assert property (
    @(posedge CLK) disable iff (RST)
    done |-> out_valid && out_last && out_row_end
  ) else $error("done without final element");

  // Operands are only gathered once the job has been running a cycle
  a_compute_in_job : assert property (
    @(posedge CLK) disable iff (RST)
    compute |-> $past(busy)
  ) else $error("compute outside a job");

endmodule

//--- matrix_index_counter.sv
/* Matrix row and column counter */

`timescale 1ns/1ps

module matrix_index_counter (
  input  logic               CLK,
  input  logic               RST,
  input  logic               clear,
  input  logic               advance,
  input  matrix_pkg::index_t size_i,
  input  matrix_pkg::index_t size_j,
  output matrix_pkg::index_t row_idx,
  output matrix_pkg::index_t col_idx,
  output logic               row_end,
  output logic               last
);

  import matrix_pkg::*;

  // Final row and column of the configured matrix
  index_t last_row;
  index_t last_col;

  assign last_row = size_i - index_t'(1);
  assign last_col = size_j - index_t'(1);

  //////////////////////////////////////////////////
  // Position markers
  //////////////////////////////////////////////////

  // Current element closes its row
  assign row_end = (col_idx == last_col);
  // Current element closes the matrix
  assign last    = row_end && (row_idx == last_row);

  //////////////////////////////////////////////////
  // Row major position
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      row_idx <= '0;
      col_idx <= '0;
    end else if (clear) begin
      // New job starts at element zero
      row_idx <= '0;
      col_idx <= '0;
    end else if (advance) begin
      if (row_end) begin
        // Wrap to the next row
        col_idx <= '0;
        row_idx <= row_idx + index_t'(1);
      end else begin
        col_idx <= col_idx + index_t'(1);
      end
    end
  end

  // Sequencer never steps past the final element and never clears mid job
  a_advance_in_range : assert property (
    @(posedge CLK) disable iff (RST)
    advance |-> !clear && (row_idx < size_i)
  ) else $error("counter advanced outside the matrix");

endmodule

//--- matrix_modular_adder.sv
/* Matrix modular adder top */

`timescale 1ns/1ps

module matrix_modular_adder (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  start,
  input  matrix_pkg::mat_cfg_t  cfg,
  input  logic                  a_valid,
  input  matrix_pkg::data_t     a_data,
  input  logic                  b_valid,
  input  matrix_pkg::data_t     b_data,
  output logic                  busy,
  output logic                  out_valid,
  output matrix_pkg::out_elem_t out_elem,
  output logic                  done
);

  import matrix_pkg::*;

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  // Configuration of the running job
  mat_cfg_t run_cfg;

  // Sequencer to datapath and counter
  logic compute;
  logic clear;
  logic advance;
  logic pair_ready;

  // Counter position
  index_t row_idx;
  index_t col_idx;
  logic   row_end;
  logic   last;

  // Result side
  data_t alu_result;
  logic  out_row_end;
  logic  out_last;

  //////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////

  matrix_add_fsm u_fsm (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .cfg_in      (cfg),
    .pair_ready  (pair_ready),
    .row_end     (row_end),
    .last        (last),
    .cfg         (run_cfg),
    .busy        (busy),
    .compute     (compute),
    .clear       (clear),
    .advance     (advance),
    .out_valid   (out_valid),
    .out_row_end (out_row_end),
    .out_last    (out_last),
    .done        (done)
  );

  matrix_index_counter u_counter (
    .CLK     (CLK),
    .RST     (RST),
    .clear   (clear),
    .advance (advance),
    .size_i  (run_cfg.size_i),
    .size_j  (run_cfg.size_j),
    .row_idx (row_idx),
    .col_idx (col_idx),
    .row_end (row_end),
    .last    (last)
  );

  // Operands only sampled during a job
  modular_add_sub u_alu (
    .CLK        (CLK),
    .RST        (RST),
    .enable     (busy),
    .a_valid    (a_valid),
    .a_data     (a_data),
    .b_valid    (b_valid),
    .b_data     (b_data),
    .compute    (compute),
    .modulus    (run_cfg.modulus),
    .op         (run_cfg.op),
    .pair_ready (pair_ready),
    .result     (alu_result)
  );

  // Result element with its markers
  assign out_elem = '{data: alu_result, row_end: out_row_end, last: out_last};

  // Every element consumed when the job ends
  a_done_at_matrix_end : assert property (
    @(posedge CLK) disable iff (RST)
    done |-> (row_idx == run_cfg.size_i) && (col_idx == '0)
  ) else $error("done before the matrix was covered");

endmodule

//--- matrix_pkg.sv
/* Matrix modular adder shared types */

package matrix_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // One matrix element or the modulus
  localparam int data_w = 32;
  // Row or column index, sizes 1 to 255
  localparam int idx_w = 8;

  typedef logic [data_w-1:0] data_t;
  typedef logic [idx_w-1:0]  index_t;

  //////////////////////////////////////////////////
  // Operation and job records
  //////////////////////////////////////////////////

  // Element operation
  typedef enum logic {
    op_add = 1'b0,
    op_sub = 1'b1
  } op_e;

  // Job configuration captured on start
  typedef struct packed {
    data_t  modulus;
    index_t size_i;
    index_t size_j;
    op_e    op;
  } mat_cfg_t;

  // One result element with its position markers
  typedef struct packed {
    data_t data;
    logic  row_end;
    logic  last;
  } out_elem_t;

endpackage

//--- modular_add_sub.sv
/* Modular add and subtract datapath */

`timescale 1ns/1ps

module modular_add_sub (
  input  logic              CLK,
  input  logic              RST,
  input  logic              enable,
  input  logic              a_valid,
  input  matrix_pkg::data_t a_data,
  input  logic              b_valid,
  input  matrix_pkg::data_t b_data,
  input  logic              compute,
  input  matrix_pkg::data_t modulus,
  input  matrix_pkg::op_e   op,
  output logic              pair_ready,
  output matrix_pkg::data_t result
);

  import matrix_pkg::*;

  // Held operands
  data_t a_reg;
  data_t b_reg;
  logic  a_held;
  logic  b_held;

  // Arithmetic
  logic [data_w:0] sum_ext;
  logic [data_w:0] sum_sub;
  data_t           sum_red;
  data_t           diff;
  data_t           diff_red;
  data_t           result_nxt;

  //////////////////////////////////////////////////
  // Operand capture
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      a_held <= 1'b0;
      b_held <= 1'b0;
    end else begin
      // Pair consumed by the sequencer
      if (compute) begin
        a_held <= 1'b0;
        b_held <= 1'b0;
      end
      if (enable && a_valid) begin
        a_held <= 1'b1;
      end
      if (enable && b_valid) begin
        b_held <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (enable && a_valid) begin
      a_reg <= a_data;
    end
    if (enable && b_valid) begin
      b_reg <= b_data;
    end
  end

  assign pair_ready = a_held && b_held;

  //////////////////////////////////////////////////
  // Modular arithmetic
  //////////////////////////////////////////////////

  // Sum keeps its carry for the compare
  assign sum_ext  = {1'b0, a_reg} + {1'b0, b_reg};
  assign sum_sub  = sum_ext - {1'b0, modulus};
  assign sum_red  = (sum_ext >= {1'b0, modulus}) ? sum_sub[data_w-1:0] : sum_ext[data_w-1:0];

  // Borrow folds back by adding the modulus
  assign diff     = a_reg - b_reg;
  assign diff_red = (a_reg < b_reg) ? diff + modulus : diff;

  assign result_nxt = (op == op_sub) ? diff_red : sum_red;

  always_ff @(posedge CLK) begin
    if (compute) begin
      result <= result_nxt;
    end
  end

  // Source waits for the pair to be consumed before the next operand
  a_no_a_overrun : assert property (
    @(posedge CLK) disable iff (RST)
    enable && a_valid |-> !a_held
  ) else $error("A strobe while A held");

  a_no_b_overrun : assert property (
    @(posedge CLK) disable iff (RST)
    enable && b_valid |-> !b_held
  ) else $error("B strobe while B held");

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the matrix modular adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

top=tb_matrix_modular_adder

if ! command -v verilator >/dev/null 2>&1; then
  echo "verilator not found on PATH"
  exit 1
fi

verilator --binary --timing --assert \
  -f filelist.f \
  --top-module "$top" \
  -o sim_"$top"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/sim_"$top" 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "test passed"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1

//--- tb_matrix_modular_adder.sv
/* Matrix modular adder testbench */

`timescale 1ns/1ps

module tb_matrix_modular_adder;

  import matrix_pkg::*;

  // Largest job is 6 by 6
  localparam int num_jobs    = 40;
  localparam int max_elems   = 36;
  localparam int cycle_limit = num_jobs * max_elems * 10 + 1000;

  logic      CLK = 1'b0;
  logic      RST;
  logic      start;
  mat_cfg_t  cfg;
  logic      a_valid;
  data_t     a_data;
  logic      b_valid;
  data_t     b_data;
  logic      busy;
  logic      out_valid;
  out_elem_t out_elem;
  logic      done;

  integer    seed = 32'hefe8;
  int        errors = 0;
  int        cycles = 0;
  int        out_count = 0;
  int        total_expected = 0;

  // Expected results in output order
  out_elem_t exp_q[$];
  out_elem_t mon_exp;

  matrix_modular_adder u_dut (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .cfg       (cfg),
    .a_valid   (a_valid),
    .a_data    (a_data),
    .b_valid   (b_valid),
    .b_data    (b_data),
    .busy      (busy),
    .out_valid (out_valid),
    .out_elem  (out_elem),
    .done      (done)
  );

  always #5 CLK = ~CLK;

  //////////////////////////////////////////////////
  // Random draws and reference model
  //////////////////////////////////////////////////

  function automatic data_t rand_word();
    rand_word = $random(seed);
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % $unsigned(n));
  endfunction

  // Small, top-bit-set and near full range moduli
  function automatic data_t draw_modulus();
    int mode;
    mode = rand_below(3);
    case (mode)
      0: return data_t'(1 + rand_below(200));
      1: return rand_word() | 32'h8000_0000;
      default: return 32'hffff_fffb - data_t'(rand_below(16));
    endcase
  endfunction

  // Configuration that must never be taken mid job
  function automatic mat_cfg_t junk_cfg();
    mat_cfg_t c;
    c.modulus = rand_word();
    c.size_i  = index_t'(rand_below(256));
    c.size_j  = index_t'(rand_below(256));
    c.op      = (rand_below(2) == 0) ? op_add : op_sub;
    return c;
  endfunction

  // Wide arithmetic keeps every carry and borrow
  function automatic data_t model_elem(input data_t a, input data_t b, input data_t m,
                                       input op_e op);
    longint unsigned x;
    if (op == op_add) begin
      x = (64'(a) + 64'(b)) % 64'(m);
    end else begin
      x = (64'(a) + 64'(m) - 64'(b)) % 64'(m);
    end
    return data_t'(x);
  endfunction

  //////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////

  task automatic compare_elem(input string name, input out_elem_t exp, input out_elem_t act);
    if (act.data !== exp.data) begin
      errors++;
      $display("Fail at %0t: %s.data expected %h actual %h", $time, name, exp.data, act.data);
    end
    if (act.row_end !== exp.row_end) begin
      errors++;
      $display("Fail at %0t: %s.row_end expected %b actual %b", $time, name,
               exp.row_end, act.row_end);
    end
    if (act.last !== exp.last) begin
      errors++;
      $display("Fail at %0t: %s.last expected %b actual %b", $time, name, exp.last, act.last);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Fail at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Result monitor and timeout
  //////////////////////////////////////////////////

  always @(posedge CLK) begin
    if (!RST) begin
      if (out_valid) begin
        out_count++;
        if (exp_q.size() == 0) begin
          errors++;
          $display("Unexpected result at %0t with no element pending", $time);
        end else begin
          mon_exp = exp_q.pop_front();
          compare_elem("out_elem", mon_exp, out_elem);
          // done only on the final element
          compare_flag("done", mon_exp.last, done);
        end
      end else begin
        compare_flag("done", 1'b0, done);
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Closing summary: %0d errors over %0d elements", errors + 1, out_count);
      $display("test failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // One operand pair with a separate gap per strobe
  task automatic present_pair(input data_t a, input data_t b, input logic extra_start);
    int ga;
    int gb;
    int gmax;
    ga   = rand_below(4);
    gb   = rand_below(4);
    gmax = (ga > gb) ? ga : gb;
    for (int t = 0; t <= gmax; t++) begin
      a_valid = (t == ga);
      a_data  = (t == ga) ? a : rand_word();
      b_valid = (t == gb);
      b_data  = (t == gb) ? b : rand_word();
      // Start while busy is dropped
      start   = extra_start && (t == 0);
      if (extra_start && (t == 0)) begin
        cfg = junk_cfg();
      end
      @(negedge CLK);
    end
    a_valid = 1'b0;
    b_valid = 1'b0;
    start   = 1'b0;
  endtask

  task automatic wait_result();
    while (!out_valid) begin
      @(negedge CLK);
    end
  endtask

  task automatic run_job(input int job);
    mat_cfg_t  c;
    data_t     a_vals[max_elems];
    data_t     b_vals[max_elems];
    out_elem_t e;
    int        si;
    int        sj;
    int        k;
    // Edge shapes come before random sizes
    case (job)
      0: begin
        si = 1;
        sj = 1;
      end
      1: begin
        si = 1;
        sj = 6;
      end
      2: begin
        si = 6;
        sj = 1;
      end
      3: begin
        si = 6;
        sj = 6;
      end
      default: begin
        si = 1 + rand_below(6);
        sj = 1 + rand_below(6);
      end
    endcase
    c.modulus = draw_modulus();
    c.size_i  = index_t'(si);
    c.size_j  = index_t'(sj);
    if (job < 4) begin
      c.op = (job % 2 == 0) ? op_add : op_sub;
    end else begin
      c.op = (rand_below(2) == 0) ? op_add : op_sub;
    end
    for (int i = 0; i < si; i++) begin
      for (int j = 0; j < sj; j++) begin
        k = i * sj + j;
        a_vals[k] = (rand_below(8) == 0) ? c.modulus - 1 : rand_word() % c.modulus;
        b_vals[k] = (rand_below(8) == 0) ? c.modulus - 1 : rand_word() % c.modulus;
        e.data    = model_elem(a_vals[k], b_vals[k], c.modulus, c.op);
        e.row_end = (j == sj - 1);
        e.last    = (k == si * sj - 1);
        exp_q.push_back(e);
      end
    end
    total_expected += si * sj;
    start = 1'b1;
    cfg   = c;
    @(negedge CLK);
    start = 1'b0;
    cfg   = junk_cfg();
    compare_flag("busy", 1'b1, busy);
    for (int n = 0; n < si * sj; n++) begin
      present_pair(a_vals[n], b_vals[n], (job % 4 == 1) && (n == 0));
      wait_result();
    end
    // Cycle of the final element
    compare_flag("done", 1'b1, done);
    compare_flag("busy", 1'b0, busy);
  endtask

  initial begin
    RST     = 1'b1;
    start   = 1'b0;
    cfg     = '0;
    a_valid = 1'b0;
    a_data  = '0;
    b_valid = 1'b0;
    b_data  = '0;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    compare_flag("busy", 1'b0, busy);
    compare_flag("out_valid", 1'b0, out_valid);
    compare_flag("done", 1'b0, done);

    // Strobes with no job running
    for (int t = 0; t < 4; t++) begin
      a_valid = 1'b1;
      a_data  = rand_word();
      b_valid = 1'b1;
      b_data  = rand_word();
      @(negedge CLK);
    end
    a_valid = 1'b0;
    b_valid = 1'b0;
    repeat (3) @(negedge CLK);
    compare_flag("busy", 1'b0, busy);

    // Zero idle cycles restarts in the done cycle
    for (int job = 0; job < num_jobs; job++) begin
      run_job(job);
      repeat (rand_below(3)) @(negedge CLK);
    end
    repeat (4) @(negedge CLK);

    if (exp_q.size() != 0) begin
      errors++;
      $display("Results missing: %0d expected elements never appeared", exp_q.size());
    end
    if (out_count != total_expected) begin
      errors++;
      $display("Fail at %0t: out_valid count expected %0d actual %0d", $time,
               total_expected, out_count);
    end
    $display("Closing summary: %0d errors over %0d elements", errors, out_count);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule
